//--- Bender.yml
package:
  name: nes_loader

sources:
  - include_dirs:
      - logic
    files:
      - logic/nes_loader_pkg.sv
      - logic/reset_ctrl.sv
      - logic/ines_header_decode.sv
      - logic/game_loader.sv
      - logic/mem_write_sync.sv
      - logic/joypad_serializer.sv
      - logic/nes_loader_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - bench/nes_loader_properties.sv
      - bench/nes_loader_tb.sv

//--- bench/nes_loader_properties.sv
/*
 * Loader front end timing rules
 * Memory strobe width, console clock enable period, reset during download
 */
`timescale 1ns/1ns

module nes_loader_properties (
	input logic                    clk,
	input logic                    reset,
	input logic                    downloading,
	input logic                    reset_nes,
	input logic                    run_nes,
	input nes_loader_pkg::mem_wr_t mem
);
	int fail_count = 0;  // Read by the testbench at the end of the run

	// A released write fills exactly one console phase
	a_we_width: assert property (@(posedge clk) disable iff (reset)
		$rose(mem.we) |-> mem.we [*4] ##1 !mem.we)
		else begin
			$error("mem.we did not stay high for exactly 4 cycles");
			fail_count++;
		end

	a_run_period: assert property (@(posedge clk) disable iff (reset)
		run_nes |=> !run_nes [*3] ##1 run_nes)
		else begin
			$error("run_nes is not a pulse every 4th cycle");
			fail_count++;
		end

	// Console must never run on a half loaded image
	a_reset_dl: assert property (@(posedge clk) disable iff (reset)
		downloading |-> reset_nes)
		else begin
			$error("reset_nes low while downloading");
			fail_count++;
		end
endmodule

bind nes_loader_top nes_loader_properties i_props (
	.clk         (clk),
	.reset       (reset),
	.downloading (downloading),
	.reset_nes   (reset_nes),
	.run_nes     (run_nes),
	.mem         (mem)
);

//--- bench/nes_loader_tb.sv
/*
 * Loader front end testbench
 * Random iNES, raw and bad images, console reset timing and joypad
 * shifting, all checked against a reference model
 */
`timescale 1ns/1ns
`include "nes_loader_params.svh"

module nes_loader_tb;
	import nes_loader_pkg::*;

	localparam int ADDR_W = `NL_ADDR_W;
	localparam int RAW_LEN = 40;
	localparam int TOTAL_BYTES = (16 + 16384 + 8192 + 2) + 2 * 18 + 3 * (16 + RAW_LEN) + 2 * 17;
	localparam int LIMIT_CYCLES = TOTAL_BYTES * 8 + 10 * (`NL_DL_RESET_CYCLES + 64) + 2000;

	logic clk, reset, downloading, dl_wr, invert_mirroring, joy_swap, reset_button;
	logic [7:0] filetype, dl_data;
	joy_t joy_a, joy_b;
	logic joypad_strobe;
	logic [1:0] joypad_clock, joypad_data;
	mem_wr_t mem;
	mapper_flags_t mapper_flags;
	logic loader_done, loader_error, reset_nes, run_nes;

	logic [31:0]      lfsr_state;
	logic [15:0][7:0] hdr;        // Header of the image in flight with byte 0 lowest
	mem_wr_t          exp_q[$];   // Writes the model expects in order
	logic             mem_we_q;
	logic             run_q;      // Console phase seen at the previous falling edge
	logic             swap_first;

	nes_loader_top i_dut (.*);

	always #5 clk = ~clk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic int size_log2(input logic [7:0] pages);
		int c;
		c = 0;
		while (c < 7 && (1 << c) < pages)
			c++;
		return c;
	endfunction

	// Reference decode of a header into the console flag word
	function automatic mapper_flags_t model_flags(input logic [15:0][7:0] h, input logic inv);
		mapper_flags_t f;
		logic nes20;
		logic dirty;
		nes20 = (h[7][3:2] == 2'b10);
		dirty = !nes20 && (h[15:8] != '0);
		f = '0;
		f.mapper = {dirty ? 4'h0 : h[7][7:4], h[6][7:4]};
		f.prg_size = 3'(size_log2(h[4]));
		f.chr_size = 3'(size_log2(h[5]));
		f.mirroring = h[6][0] ^ inv;
		f.has_chr_ram = (h[5] == 8'h00);
		f.four_screen = h[6][3];
		f.submapper = nes20 ? h[8] : 8'h00;
		return f;
	endfunction

	// Buttons leave A first in declaration order and zeros follow
	function automatic logic serial_bit(input joy_t pad, input int n);
		return (n < 8) ? pad[7 - n] : 1'b0;
	endfunction

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_mem(input mem_wr_t got, input mem_wr_t exp);
		if (got.addr !== exp.addr || got.data !== exp.data)
			fail_run($sformatf("error mem: expected addr %h data %h, got addr %h data %h",
				exp.addr, exp.data, got.addr, got.data));
	endtask

	task automatic check_flags(input mapper_flags_t got, input mapper_flags_t exp);
		if (got !== exp)
			fail_run($sformatf("error mapper_flags: expected %h, got %h", exp, got));
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			fail_run($sformatf("error %s: expected %h, got %h", name, exp, got));
	endtask

	task automatic cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	// Each rising edge of the memory strobe consumes one expected write
	always @(negedge clk) begin
		if (mem.we === 1'b1 && mem_we_q !== 1'b1) begin
			check_bit("run_nes", run_q, 1'b1);  // Release starts on the phase 3 edge
			if (exp_q.size() == 0)
				fail_run($sformatf("unexpected memory write to address %h", mem.addr));
			else
				check_mem(mem, exp_q.pop_front());
		end
		mem_we_q = mem.we;
		run_q = run_nes;
	end

	initial begin
		repeat (LIMIT_CYCLES) @(posedge clk);
		$display("Run did not finish within %0d cycles", LIMIT_CYCLES);
		$display("Verification failed");
		$fatal(1);
	end

	task automatic send_byte(input logic [7:0] d, input logic wr, input logic [21:0] a);
		mem_wr_t w;
		w.addr = a;
		w.data = d;
		w.we = 1'b1;
		if (wr)
			exp_q.push_back(w);
		dl_data = d;
		dl_wr = 1'b1;
		cycles(1);
		dl_wr = 1'b0;
		cycles(7);  // Keeps strobes 8 cycles apart
	endtask

	task automatic fill_header();
		for (int i = 0; i < 16; i++)
			hdr[i] = 8'(rand_bits(8));
	endtask

	task automatic make_ines_header(input logic [7:0] prg, input logic [7:0] chr);
		fill_header();
		hdr[3:0] = 32'h1A53454E;  // "NES" 0x1A
		hdr[4] = prg;
		hdr[5] = chr;
		hdr[6][2] = 1'b0;
	endtask

	task automatic start_download(input logic [7:0] ft);
		filetype = ft;
		cycles(1);
		downloading = 1'b1;
		cycles(1);
		check_bit("reset_nes", reset_nes, 1'b1);
	endtask

	task automatic send_header(input logic [7:0] ft);
		logic [`NL_ADDR_W-1:0] base;
		base = (ft == `NL_FT_FDS) ? `NL_FDS_HDR_BASE : '0;
		for (int i = 0; i < 16; i++)
			send_byte(hdr[i], 1'b1, base + ADDR_W'(i));
	endtask

	task automatic wait_writes();
		for (int n = 0; n < 16 && exp_q.size() != 0; n++)
			cycles(1);
		if (exp_q.size() != 0)
			fail_run($sformatf("%0d expected memory writes never appeared", exp_q.size()));
	endtask

	task automatic wait_done(input logic exp_err);
		for (int n = 0; n < 64 && loader_done !== 1'b1; n++)
			cycles(1);
		if (loader_done !== 1'b1)
			fail_run("loader_done never rose after the image ended");
		check_bit("loader_error", loader_error, exp_err);
	endtask

	// Drops downloading and follows the console reset tail edge by edge
	task automatic end_download(input logic exp_rst, input mapper_flags_t exp_flags);
		downloading = 1'b0;
		for (int k = 1; k <= `NL_DL_RESET_CYCLES; k++) begin
			cycles(1);
			check_bit("reset_nes", reset_nes, exp_rst || (k < `NL_DL_RESET_CYCLES));
			if (!exp_rst && k == 2) begin
				check_bit("loader_done", loader_done, 1'b1);
				check_flags(mapper_flags, exp_flags);
			end
		end
		cycles(2);
		check_bit("reset_nes", reset_nes, exp_rst);
	endtask

	task automatic run_ines(input logic [7:0] ft);
		int prg_len;
		int chr_len;
		prg_len = int'(hdr[4]) << `NL_PRG_PAGE_LOG2;
		chr_len = int'(hdr[5]) << `NL_CHR_PAGE_LOG2;
		start_download(ft);
		send_header(ft);
		for (int i = 0; i < prg_len; i++)
			send_byte(8'(rand_bits(8)), 1'b1, ADDR_W'(i));
		for (int i = 0; i < chr_len; i++)
			send_byte(8'(rand_bits(8)), 1'b1, `NL_CHR_BASE + ADDR_W'(i));
		wait_done(1'b0);
		send_byte(8'(rand_bits(8)), 1'b0, '0);  // Bytes past the image are dropped
		send_byte(8'(rand_bits(8)), 1'b0, '0);
		wait_writes();
		end_download(1'b0, model_flags(hdr, invert_mirroring));
	endtask

	task automatic run_raw(input logic [7:0] ft, input logic [21:0] raw_base);
		logic [15:0][7:0] def;
		start_download(ft);
		send_header(ft);
		for (int i = 0; i < RAW_LEN; i++)
			send_byte(8'(rand_bits(8)), 1'b1, raw_base + ADDR_W'(i));
		wait_writes();
		def = hdr;
		def[4] = 8'hFF;
		def[5] = 8'h00;
		def[6] = 8'h40;
		def[7] = 8'h10;
		def[15:8] = '0;
		end_download(1'b0, model_flags(def, invert_mirroring));
	endtask

	task automatic run_bad(input logic [7:0] ft);
		start_download(ft);
		send_header(ft);
		wait_done(1'b1);
		check_bit("reset_nes", reset_nes, 1'b1);
		send_byte(8'(rand_bits(8)), 1'b0, '0);
		wait_writes();
		end_download(1'b1, '0);
	endtask

	task automatic run_joypad(input logic swap);
		joy_t pad0;
		joy_t pad1;
		int cnt0;
		int cnt1;
		logic [1:0] pick;
		joy_a = joy_t'(8'(rand_bits(8)));
		joy_b = joy_t'(8'(rand_bits(8)));
		joy_swap = swap;
		pad0 = joy_swap ? joy_b : joy_a;
		pad1 = joy_swap ? joy_a : joy_b;
		cnt0 = 0;
		cnt1 = 0;
		joypad_strobe = 1'b1;
		cycles(1);
		joypad_strobe = 1'b0;
		for (int step = 0; step <= 24; step++) begin
			cycles(1);
			check_bit("joypad_data[0]", joypad_data[0], serial_bit(pad0, cnt0));
			check_bit("joypad_data[1]", joypad_data[1], serial_bit(pad1, cnt1));
			pick = 2'(rand_bits(2));
			joypad_clock = pick;
			cycles(1);
			joypad_clock = 2'b00;  // Shift lands on the edge after this fall
			cnt0 += pick[0];
			cnt1 += pick[1];
		end
	endtask

	initial begin
		lfsr_state = 32'hbddf;
		clk = 1'b0;
		reset = 1'b1;
		{downloading, dl_wr, invert_mirroring, joy_swap, reset_button} = '0;
		filetype = 8'h00;
		dl_data = 8'h00;
		joy_a = '0;
		joy_b = '0;
		joypad_strobe = 1'b0;
		joypad_clock = 2'b00;
		cycles(2);
		reset = 1'b0;
		cycles(1);
		check_bit("reset_nes", reset_nes, 1'b1);  // Parked before the first load
		check_bit("mem.we", mem.we, 1'b0);
		check_bit("loader_done", loader_done, 1'b0);
		check_bit("loader_error", loader_error, 1'b0);
		check_bit("joypad_data[0]", joypad_data[0], 1'b0);
		check_bit("joypad_data[1]", joypad_data[1], 1'b0);

		invert_mirroring = 1'(rand_bits(1));
		make_ines_header(8'd1, 8'(rand_bits(1)));
		run_ines(8'h01);

		reset_button = 1'b1;
		cycles(1);
		check_bit("reset_nes", reset_nes, 1'b1);
		reset_button = 1'b0;
		cycles(1);
		check_bit("reset_nes", reset_nes, 1'b0);
		swap_first = 1'(rand_bits(1));
		run_joypad(swap_first);
		run_joypad(!swap_first);

		make_ines_header(8'd0, 8'd0);
		hdr[7][3:2] = 2'b00;
		hdr[7][7] = 1'b1;         // Mapper high nibble that the dirty tail must clear
		hdr[8] = hdr[8] | 8'h01;  // Dirty 1.0 tail
		run_ines(8'h01);
		make_ines_header(8'd0, 8'd0);
		hdr[7][3:2] = 2'b10;
		run_ines(8'h01);

		invert_mirroring = 1'(rand_bits(1));
		fill_header();
		hdr[0] = 8'h00;
		run_raw(`NL_FT_BIOS, `NL_BIOS_BASE);
		fill_header();
		hdr[0] = 8'h00;
		run_raw(`NL_FT_FDS, `NL_FDS_RAW_BASE);
		fill_header();
		hdr[3:0] = 32'h1A534446;  // "FDS" 0x1A
		run_raw(`NL_FT_FDS, `NL_FDS_HDR_BASE);

		fill_header();
		hdr[0] = 8'h00;
		run_bad(8'(rand_bits(1)));
		make_ines_header(8'd1, 8'd0);
		hdr[6][2] = 1'b1;  // Trainer present
		run_bad(8'h01);

		cycles(4);
		if (i_dut.i_props.fail_count == 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			$display("%0d timing assertions failed", i_dut.i_props.fail_count);
			$display("Verification failed");
			$fatal(1);
		end
	end
endmodule

//--- files.f
+incdir+logic
logic/nes_loader_pkg.sv
logic/reset_ctrl.sv
logic/ines_header_decode.sv
logic/game_loader.sv
logic/mem_write_sync.sv
logic/joypad_serializer.sv
logic/nes_loader_top.sv
bench/nes_loader_properties.sv
bench/nes_loader_tb.sv

//--- logic/game_loader.sv
/*
 * Game loader
 * Stores the iNES header and routes PRG, CHR and raw image bytes
 * to their memory addresses, then latches the mapper flags
 */
`timescale 1ns/1ns
`include "nes_loader_params.svh"

module game_loader (
	input  logic                          clk,
	input  logic                          loader_reset,
	input  logic                          downloading,
	input  logic [7:0]                    filetype,
	input  logic [7:0]                    dl_data,
	input  logic                          dl_wr,
	input  logic                          invert_mirroring,
	output nes_loader_pkg::mem_wr_t       wr_req,
	output nes_loader_pkg::mapper_flags_t mapper_flags,
	output logic                          loader_done,
	output logic                          loader_error
);
	import nes_loader_pkg::*;

	localparam int ADDR_W = `NL_ADDR_W;
	localparam int CTR_W = $clog2(`NL_HDR_BYTES);

	typedef enum logic [2:0] {
		ST_HEADER,
		ST_PRG,
		ST_CHR,
		ST_ERROR,
		ST_RAW
	} state_t;

	state_t                        state;
	logic [CTR_W-1:0]              ctr;
	logic [`NL_HDR_BYTES-1:0][7:0] ines;  // Header bytes, byte 0 lowest
	logic [ADDR_W-1:0]             addr;
	logic [ADDR_W-1:0]             bytes_left;
	logic                          header_ok;
	logic                          fds_magic;
	logic [7:0]                    prg_pages;
	logic [7:0]                    chr_pages;
	mapper_flags_t                 flags;
	logic                          copy_byte;
	logic                          stream_byte;

	ines_header_decode i_decode (
		.header           (ines),
		.invert_mirroring (invert_mirroring),
		.header_ok        (header_ok),
		.fds_magic        (fds_magic),
		.prg_pages        (prg_pages),
		.chr_pages        (chr_pages),
		.flags            (flags)
	);

	assign copy_byte = ((state == ST_PRG) || (state == ST_CHR)) && (bytes_left != '0);
	assign stream_byte = downloading && ((state == ST_HEADER) || (state == ST_RAW));

	// Request goes out in the cycle of the strobe
	assign wr_req.addr = addr;
	assign wr_req.data = dl_data;
	assign wr_req.we = dl_wr && (copy_byte || stream_byte);

	always_ff @(posedge clk) begin
		if (loader_reset) begin
			state <= ST_HEADER;
			ctr <= '0;
			addr <= (filetype == `NL_FT_FDS) ? `NL_FDS_HDR_BASE : '0;
			bytes_left <= '0;
			loader_done <= 1'b0;
			loader_error <= 1'b0;
		end else begin
			case (state)
				ST_HEADER: if (dl_wr && downloading) begin
					ines[ctr] <= dl_data;
					ctr <= ctr + 1'b1;
					addr <= addr + 1'b1;
					if (ctr == CTR_W'(`NL_HDR_BYTES - 1)) begin
						if (header_ok) begin
							state <= ST_PRG;
							addr <= '0;
							bytes_left <= ADDR_W'(prg_pages) << `NL_PRG_PAGE_LOG2;
						end else if (fds_magic) begin
							state <= ST_RAW;
							addr <= `NL_FDS_HDR_BASE;  // Header is overwritten
						end else if (filetype == `NL_FT_BIOS) begin
							state <= ST_RAW;
							addr <= `NL_BIOS_BASE;
						end else if (filetype == `NL_FT_FDS) begin
							state <= ST_RAW;
							addr <= `NL_FDS_RAW_BASE;
						end else begin
							state <= ST_ERROR;
						end
					end
				end
				ST_PRG, ST_CHR: begin
					if (bytes_left != '0) begin
						if (dl_wr) begin
							bytes_left <= bytes_left - 1'b1;
							addr <= addr + 1'b1;
						end
					end else if (state == ST_PRG) begin
						state <= ST_CHR;
						addr <= `NL_CHR_BASE;
						bytes_left <= ADDR_W'(chr_pages) << `NL_CHR_PAGE_LOG2;
					end else begin
						loader_done <= 1'b1;
					end
				end
				ST_RAW: begin
					if (downloading) begin
						if (dl_wr)
							addr <= addr + 1'b1;
					end else begin
						// Default header gives mapper 0x14 with CHR RAM
						loader_done <= 1'b1;
						ines[4] <= 8'hFF;
						ines[5] <= 8'h00;
						ines[6] <= 8'h40;
						ines[7] <= 8'h10;
						ines[15:8] <= '0;
					end
				end
				default: begin  // ST_ERROR
					loader_done <= 1'b1;
					loader_error <= 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (loader_done)
			mapper_flags <= flags;
	end
endmodule

//--- logic/ines_header_decode.sv
/*
 * iNES header decoder
 * Magic checks, page counts and the console mapper flag word
 */
`timescale 1ns/1ns
`include "nes_loader_params.svh"

module ines_header_decode (
	input  logic [`NL_HDR_BYTES*8-1:0]  header,
	input  logic                        invert_mirroring,
	output logic                        header_ok,
	output logic                        fds_magic,
	output logic [7:0]                  prg_pages,
	output logic [7:0]                  chr_pages,
	output nes_loader_pkg::mapper_flags_t flags
);
	logic [`NL_HDR_BYTES-1:0][7:0] b;
	logic                          is_nes20;
	logic                          is_dirty;

	// Ceiling log2 of a page count, saturating at 7
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		code = 3'd7;
		for (int i = 6; i >= 0; i--)
			if (pages <= (8'd1 << i))
				code = 3'(i);
		return code;
	endfunction

	assign b = header;

	// "NES" 0x1A, trainers are not supported
	assign header_ok = (b[0] == 8'h4E) && (b[1] == 8'h45) && (b[2] == 8'h53) &&
		(b[3] == 8'h1A) && !b[6][2];
	assign fds_magic = (b[0] == 8'h46) && (b[1] == 8'h44) && (b[2] == 8'h53) &&
		(b[3] == 8'h1A);

	assign is_nes20 = (b[7][3:2] == 2'b10);
	assign is_dirty = !is_nes20 && (b[15:8] != '0);  // Junk in the tail of a 1.0 header

	assign prg_pages = b[4];
	assign chr_pages = b[5];

	assign flags.pad = '0;
	assign flags.submapper = is_nes20 ? b[8] : 8'h00;
	assign flags.four_screen = b[6][3];
	assign flags.has_chr_ram = (chr_pages == 8'h00);
	assign flags.mirroring = b[6][0] ^ invert_mirroring;
	assign flags.chr_size = size_code(chr_pages);
	assign flags.prg_size = size_code(prg_pages);
	assign flags.mapper = {is_dirty ? 4'h0 : b[7][7:4], b[6][7:4]};
endmodule

//--- logic/joypad_serializer.sv
/*
 * Controller port serializer
 * Loads both pads on strobe and shifts each port out on its clock
 */
`timescale 1ns/1ns

module joypad_serializer (
	input  logic                 clk,
	input  logic                 reset_nes,
	input  nes_loader_pkg::joy_t joy_a,
	input  nes_loader_pkg::joy_t joy_b,
	input  logic                 joy_swap,
	input  logic                 joypad_strobe,
	input  logic [1:0]           joypad_clock,
	output logic [1:0]           joypad_data
);
	import nes_loader_pkg::*;

	logic [1:0][7:0] load_val;
	logic [1:0][7:0] shift_q;
	logic [1:0]      clk_q;  // Previous port clocks for edge detect

	// Console reads A first, right last
	function automatic logic [7:0] serial_order(input joy_t pad);
		return {pad.right, pad.left, pad.down, pad.up, pad.start, pad.select, pad.b, pad.a};
	endfunction

	assign load_val[0] = serial_order(joy_swap ? joy_b : joy_a);
	assign load_val[1] = serial_order(joy_swap ? joy_a : joy_b);

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			shift_q <= '0;
			clk_q <= '0;
		end else begin
			clk_q <= joypad_clock;
			for (int i = 0; i < 2; i++) begin
				if (joypad_strobe)
					shift_q[i] <= load_val[i];
				else if (clk_q[i] && !joypad_clock[i])  // Falling edge of this port's clock
					shift_q[i] <= {1'b0, shift_q[i][7:1]};
			end
		end
	end

	assign joypad_data = {shift_q[1][0], shift_q[0][0]};
endmodule

//--- logic/mem_write_sync.sv
/*
 * Memory write synchronizer
 * Owns the console clock enable phase and holds a loader write
 * until the memory slot, then presents it for one full phase
 */
`timescale 1ns/1ns
`include "nes_loader_params.svh"

module mem_write_sync (
	input  logic                    clk,
	input  logic                    reset,
	input  nes_loader_pkg::mem_wr_t wr_req,
	output nes_loader_pkg::mem_wr_t mem,
	output logic                    run_nes
);
	localparam int CE_W = $clog2(`NL_CE_DIV);
	localparam logic [CE_W-1:0] CE_SLOT = CE_W'(`NL_CE_DIV - 1);

	logic [CE_W-1:0]       ce_cnt;
	logic                  slot;
	logic                  pending;  // Write waiting for the slot
	logic                  we_q;
	logic [`NL_ADDR_W-1:0] hold_addr;
	logic [7:0]            hold_data;

	assign slot = (ce_cnt == CE_SLOT);

	always_ff @(posedge clk) begin
		if (reset) begin
			ce_cnt <= '0;
			pending <= 1'b0;
			we_q <= 1'b0;
		end else begin
			ce_cnt <= ce_cnt + 1'b1;
			if (slot) begin
				we_q <= pending | wr_req.we;  // A request in the slot cycle goes straight out
				pending <= 1'b0;
			end else if (wr_req.we) begin
				pending <= 1'b1;
			end
		end
	end

	// Last request wins, there is no back-pressure
	always_ff @(posedge clk) begin
		if (wr_req.we) begin
			hold_addr <= wr_req.addr;
			hold_data <= wr_req.data;
		end
	end

	assign mem = '{addr: hold_addr, data: hold_data, we: we_q};
	assign run_nes = slot;
endmodule

//--- logic/nes_loader_params.svh
/*
 * Loader front end constants
 * Header layout, image base addresses, page sizes and timing counts
 */
`ifndef NES_LOADER_PARAMS_SVH
`define NES_LOADER_PARAMS_SVH

// Memory port
`define NL_ADDR_W           22
`define NL_HDR_BYTES        16

// Page sizes as shifts
`define NL_PRG_PAGE_LOG2    14
`define NL_CHR_PAGE_LOG2    13

// Image base addresses
`define NL_CHR_BASE         22'h200000
`define NL_FDS_HDR_BASE     22'h010010
`define NL_FDS_RAW_BASE     22'h010020
`define NL_BIOS_BASE        22'h000010

// Download file types
`define NL_FT_BIOS          8'h02
`define NL_FT_FDS           8'h03

`define NL_DL_RESET_CYCLES  255  // Console reset tail after a download
`define NL_CE_DIV           4    // Console runs on one clock in four

`endif

//--- logic/nes_loader_pkg.sv
/*
 * Loader front end types
 * Mapper flag word, memory write request and controller pad
 */
`include "nes_loader_params.svh"

package nes_loader_pkg;

	// Flag word handed to the console, LSB first is mapper
	typedef struct packed {
		logic [6:0] pad;
		logic [7:0] submapper;   // iNES 2.0 only
		logic       four_screen;
		logic       has_chr_ram;
		logic       mirroring;
		logic [2:0] chr_size;    // Ceiling log2 of CHR pages
		logic [2:0] prg_size;    // Ceiling log2 of PRG pages
		logic [7:0] mapper;
	} mapper_flags_t;

	typedef struct packed {
		logic [`NL_ADDR_W-1:0] addr;
		logic [7:0]            data;
		logic                  we;
	} mem_wr_t;

	// One pad, buttons as the host reports them
	typedef struct packed {
		logic a;
		logic b;
		logic select;
		logic start;
		logic up;
		logic down;
		logic left;
		logic right;
	} joy_t;

endpackage

//--- logic/nes_loader_top.sv
/*
 * NES cartridge loader front end
 * Download parsing, memory write timing, console reset and joypads
 */
`timescale 1ns/1ns

module nes_loader_top (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          downloading,
	input  logic [7:0]                    filetype,
	input  logic [7:0]                    dl_data,
	input  logic                          dl_wr,
	input  logic                          invert_mirroring,
	input  logic                          joy_swap,
	input  logic                          reset_button,
	input  nes_loader_pkg::joy_t          joy_a,
	input  nes_loader_pkg::joy_t          joy_b,
	input  logic                          joypad_strobe,
	input  logic [1:0]                    joypad_clock,
	output nes_loader_pkg::mem_wr_t       mem,
	output nes_loader_pkg::mapper_flags_t mapper_flags,
	output logic                          loader_done,
	output logic                          loader_error,
	output logic                          reset_nes,
	output logic                          run_nes,
	output logic [1:0]                    joypad_data
);
	import nes_loader_pkg::*;

	mem_wr_t wr_req;        // Loader request before slot alignment
	logic    loader_reset;

	reset_ctrl i_reset_ctrl (
		.clk          (clk),
		.reset        (reset),
		.downloading  (downloading),
		.reset_button (reset_button),
		.loader_error (loader_error),
		.reset_nes    (reset_nes),
		.loader_reset (loader_reset)
	);

	game_loader i_game_loader (
		.clk              (clk),
		.loader_reset     (loader_reset),
		.downloading      (downloading),
		.filetype         (filetype),
		.dl_data          (dl_data),
		.dl_wr            (dl_wr),
		.invert_mirroring (invert_mirroring),
		.wr_req           (wr_req),
		.mapper_flags     (mapper_flags),
		.loader_done      (loader_done),
		.loader_error     (loader_error)
	);

	mem_write_sync i_mem_write_sync (
		.clk     (clk),
		.reset   (reset),
		.wr_req  (wr_req),
		.mem     (mem),
		.run_nes (run_nes)
	);

	joypad_serializer i_joypad_serializer (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.joy_a         (joy_a),
		.joy_b         (joy_b),
		.joy_swap      (joy_swap),
		.joypad_strobe (joypad_strobe),
		.joypad_clock  (joypad_clock),
		.joypad_data   (joypad_data)
	);
endmodule

//--- logic/reset_ctrl.sv
/*
 * Console reset generator
 * Parks the console until the first download and holds it in reset
 * during a download, for a fixed tail after it, and on button or error
 */
`timescale 1ns/1ns
`include "nes_loader_params.svh"

module reset_ctrl (
	input  logic clk,
	input  logic reset,
	input  logic downloading,
	input  logic reset_button,
	input  logic loader_error,
	output logic reset_nes,
	output logic loader_reset
);
	localparam int CNT_W = $clog2(`NL_DL_RESET_CYCLES + 1);

	logic             init_hold;  // Set until a download starts
	logic [CNT_W-1:0] dl_cnt;
	logic             dl_tail;

	assign dl_tail = (dl_cnt != '0);

	always_ff @(posedge clk) begin
		if (reset) begin
			init_hold <= 1'b1;
			dl_cnt <= '0;
		end else begin
			// A failed load keeps the console parked until the next download
			if (loader_error)
				init_hold <= 1'b1;
			else if (downloading)
				init_hold <= 1'b0;

			if (downloading)
				dl_cnt <= CNT_W'(`NL_DL_RESET_CYCLES);  // Reload while bytes arrive
			else if (dl_tail)
				dl_cnt <= dl_cnt - 1'b1;
		end
	end

	assign reset_nes = init_hold | reset_button | downloading | loader_error | dl_tail;
	assign loader_reset = ~(downloading | dl_tail);  // Loader runs only in the download window
endmodule
